// File: Bender.yml
package:
  name: backend_merge

sources:
  # Packages first, then the modules bottom up
  - files:
      - hdl/core_cfg_pkg.sv
      - hdl/core_types_pkg.sv
      - hdl/lane_select.sv
      - hdl/redirect_unit.sv
      - hdl/regs_file.sv
      - hdl/backend_merge_top.sv

  # Testbench with the bound assertion checker
  - target: test
    files:
      - dv/backend_merge_checker.sv
      - dv/backend_merge_tb.sv

// File: dv/backend_merge_checker.sv
module backend_merge_checker
    import core_cfg_pkg::*;
    import core_types_pkg::*;
(
    input logic                                       clk,
    input logic                                       reset_i,
    input wb_reg_t       [LANES-1:0]                  wb_i,
    input logic          [READ_PORTS-1:0][REG_ADDR_W-1:0] rd_addr_i,
    input logic          [READ_PORTS-1:0][XLEN-1:0]       rd_data_o,
    input mem_req_t      [LANES-1:0]                  mem_req_i,
    input mem_req_t                                   dcache_req_o,
    input except_t                                    except_i,
    input redirect_vec_t                              redirect_vec_i,
    input branch_t       [LANES-1:0]                  branch_i,
    input logic                                       ex_stall_i,
    input redirect_t                                  redirect_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // Read by the testbench at the end of each test

    logic                            prev_reset;  // X until the first edge
    wb_reg_t  [LANES-1:0]            prev_wb;
    mem_req_t [LANES-1:0]            prev_mem;
    except_t                         prev_except;
    redirect_vec_t                   prev_vec;
    branch_t  [LANES-1:0]            prev_branch;
    logic                            prev_stall;

    redirect_t                       exp_redirect;
    mem_req_t                        exp_dcache;
    logic                            any_prev_ce;
    logic [READ_PORTS-1:0]           exp_hit;
    logic [READ_PORTS-1:0][XLEN-1:0] exp_data;

    // Every output under check answers the inputs of the previous edge
    always_ff @(posedge clk) begin
        prev_reset  <= reset_i;
        prev_wb     <= wb_i;
        prev_mem    <= mem_req_i;
        prev_except <= except_i;
        prev_vec    <= redirect_vec_i;
        prev_branch <= branch_i;
        prev_stall  <= ex_stall_i;
    end

    // Exception, ertn, idle, refetch, then lane 0 and lane 1 branches
    function automatic redirect_t expected_redirect(
        input except_t             ev,
        input redirect_vec_t       vec,
        input branch_t [LANES-1:0] br,
        input logic                stall
    );
        redirect_t r;
        r        = '0;
        r.flush  = 1'b1;
        r.ftq_id = vec.ctrl_ftq_id;
        if (ev.excp) begin
            r.next_pc = ev.tlbrefill ? vec.tlbrentry : vec.eentry;
        end else if (ev.ertn) begin
            r.next_pc = vec.era;
        end else if (ev.idle) begin
            r.next_pc = vec.idle_pc;
        end else if (ev.refetch) begin
            r.next_pc = vec.idle_pc + INSTR_BYTES;
        end else if (!stall && br[0].taken) begin
            r.next_pc = br[0].target;
            r.ftq_id  = br[0].ftq_id;
        end else if (!stall && br[1].taken) begin
            r.next_pc = br[1].target;
            r.ftq_id  = br[1].ftq_id;
        end else begin
            r = '0;  // Nothing to redirect
        end
        return r;
    endfunction

    always_comb begin
        exp_redirect = expected_redirect(prev_except, prev_vec, prev_branch, prev_stall);
        any_prev_ce  = prev_mem[0].ce | prev_mem[1].ce;
        exp_dcache   = prev_mem[0].ce ? prev_mem[0] : prev_mem[1];
    end

    // Younger lane overrides on an equal address
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            exp_hit[p]  = 1'b0;
            exp_data[p] = '0;
            for (int l = 0; l < LANES; l++) begin
                if (prev_wb[l].we && prev_wb[l].waddr != '0
                        && prev_wb[l].waddr == rd_addr_i[p]) begin
                    exp_hit[p]  = 1'b1;
                    exp_data[p] = prev_wb[l].wdata;
                end
            end
        end
    end

    a_reset_flush: assert property (@(posedge clk) prev_reset |-> !redirect_o.flush)
        else begin
            fail_count++;
            $error("Mismatch at %0t: redirect_o.flush expected 0 got %b",
                   $time, $sampled(redirect_o.flush));
        end

    a_reset_dcache: assert property (@(posedge clk) prev_reset |-> !dcache_req_o.ce)
        else begin
            fail_count++;
            $error("Mismatch at %0t: dcache_req_o.ce expected 0 got %b",
                   $time, $sampled(dcache_req_o.ce));
        end

    a_dcache_req: assert property (@(posedge clk)
            !prev_reset && any_prev_ce |-> dcache_req_o == exp_dcache)
        else begin
            fail_count++;
            $error("Mismatch at %0t: dcache_req_o expected %h got %h",
                   $time, $sampled(exp_dcache), $sampled(dcache_req_o));
        end

    a_dcache_idle: assert property (@(posedge clk)
            !prev_reset && !any_prev_ce |-> !dcache_req_o.ce)
        else begin
            fail_count++;
            $error("Mismatch at %0t: dcache_req_o.ce expected 0 got %b",
                   $time, $sampled(dcache_req_o.ce));
        end

    a_redirect: assert property (@(posedge clk)
            !prev_reset && exp_redirect.flush |-> redirect_o == exp_redirect)
        else begin
            fail_count++;
            $error("Mismatch at %0t: redirect_o expected %h got %h",
                   $time, $sampled(exp_redirect), $sampled(redirect_o));
        end

    a_no_redirect: assert property (@(posedge clk)
            !prev_reset && !exp_redirect.flush |-> !redirect_o.flush)
        else begin
            fail_count++;
            $error("Mismatch at %0t: redirect_o.flush expected 0 got %b",
                   $time, $sampled(redirect_o.flush));
        end

    for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
        a_r0_zero: assert property (@(posedge clk) rd_addr_i[p] == '0 |-> rd_data_o[p] == '0)
            else begin
                fail_count++;
                $error("Mismatch at %0t: rd_data_o[%0d] expected 0 got %h",
                       $time, p, $sampled(rd_data_o[p]));
            end

        // Reset contents hold until the first write after reset
        a_reset_read: assert property (@(posedge clk) prev_reset |-> rd_data_o[p] == '0)
            else begin
                fail_count++;
                $error("Mismatch at %0t: rd_data_o[%0d] expected 0 got %h",
                       $time, p, $sampled(rd_data_o[p]));
            end

        a_write_read: assert property (@(posedge clk)
                !prev_reset && exp_hit[p] |-> rd_data_o[p] == exp_data[p])
            else begin
                fail_count++;
                $error("Mismatch at %0t: rd_data_o[%0d] expected %h got %h",
                       $time, p, $sampled(exp_data[p]), $sampled(rd_data_o[p]));
            end
    end

endmodule

bind backend_merge_top backend_merge_checker u_checker (.*);

// File: dv/backend_merge_tb.sv
module backend_merge_tb
    import core_cfg_pkg::*;
    import core_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_PERIOD   = 40;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned NUM_WRITES   = 48;
    localparam int unsigned NUM_MEM      = 32;
    localparam int unsigned NUM_EVENTS   = 64;
    localparam int unsigned NUM_BRANCHES = 32;
    localparam int unsigned DRAIN        = 2;  // Edges until the last check has fired
    localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + DRAIN
        + NUM_WRITES + NUM_MEM + NUM_EVENTS + NUM_BRANCHES + 4 * (1 + DRAIN);
    localparam int unsigned WATCHDOG_NS  = TOTAL_CYCLES * 3 / 2 * CLK_PERIOD;

    logic                                  clk;
    logic                                  reset_i;
    wb_reg_t       [LANES-1:0]             wb_i;
    logic          [READ_PORTS-1:0][REG_ADDR_W-1:0] rd_addr_i;
    logic          [READ_PORTS-1:0][XLEN-1:0]       rd_data_o;
    mem_req_t      [LANES-1:0]             mem_req_i;
    mem_req_t                              dcache_req_o;
    except_t                               except_i;
    redirect_vec_t                         redirect_vec_i;
    branch_t       [LANES-1:0]             branch_i;
    logic                                  ex_stall_i;
    redirect_t                             redirect_o;

    int unsigned tests_run;
    int unsigned tests_failed;

    backend_merge_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic int unsigned assertion_failures();
        return dut0.u_checker.fail_count;
    endfunction

    function automatic mem_req_t build_mem_req(input logic ce);
        mem_req_t req;
        req.ce   = ce;
        req.we   = 1'($urandom);
        req.sel  = STRB_W'($urandom);
        req.addr = $urandom;
        req.data = $urandom;
        return req;
    endfunction

    function automatic branch_t random_branch(input logic taken);
        branch_t br;
        br.taken  = taken;
        br.target = $urandom;
        br.ftq_id = FTQ_ID_W'($urandom);
        return br;
    endfunction

    function automatic redirect_vec_t event_targets();
        redirect_vec_t vec;
        vec.eentry      = $urandom;
        vec.tlbrentry   = $urandom;
        vec.era         = $urandom;
        vec.idle_pc     = $urandom;
        vec.ctrl_ftq_id = FTQ_ID_W'($urandom);
        return vec;
    endfunction

    task automatic randomize_reads();
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_addr_i[p] = REG_ADDR_W'($urandom);
        end
    endtask

    // Writes, requests, branches and events all at random
    task automatic drive_random_strobes();
        for (int l = 0; l < LANES; l++) begin
            wb_i[l].we    = 1'($urandom);
            wb_i[l].waddr = REG_ADDR_W'($urandom);
            wb_i[l].wdata = $urandom;
            wb_i[l].pc    = $urandom;
            mem_req_i[l]  = build_mem_req(1'($urandom));
            branch_i[l]   = random_branch(1'($urandom));
        end
        except_i       = 5'($urandom);
        redirect_vec_i = event_targets();
        ex_stall_i     = 1'($urandom);
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    task automatic close_test(input string name, input int unsigned start);
        int unsigned fails;
        fails = assertion_failures() - start;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("%-16s %s, %0d assertion failures", name, (fails == 0) ? "ok" : "FAILED", fails);
    endtask

    // Strobes keep arriving under reset, none of them may leak past it
    task automatic apply_reset();
        reset_i = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            randomize_reads();
            drive_random_strobes();
        end
        reset_i    = 1'b0;
        wb_i       = '0;
        mem_req_i  = '0;
        except_i   = '0;
        branch_i   = '0;
        ex_stall_i = 1'b0;
        for (int c = 0; c < DRAIN; c++) begin
            @(negedge clk);
            randomize_reads();
        end
    endtask

    // Each cycle reads back the addresses written on the edge before
    task automatic write_and_read_registers();
        logic [LANES-1:0][REG_ADDR_W-1:0] last_addr;
        last_addr = '0;
        for (int i = 0; i < NUM_WRITES; i++) begin
            @(negedge clk);
            rd_addr_i[0]  = last_addr[0];
            rd_addr_i[1]  = last_addr[1];
            rd_addr_i[2]  = '0;
            rd_addr_i[3]  = REG_ADDR_W'($urandom);
            wb_i[0].we    = 1'b1;
            wb_i[0].waddr = (i % 8 == 0) ? '0 : REG_ADDR_W'($urandom);  // r0 attempts
            wb_i[0].wdata = $urandom;
            wb_i[0].pc    = $urandom;
            wb_i[1].we    = (i % 4 == 1) ? 1'b1 : 1'($urandom);
            wb_i[1].waddr = (i % 4 == 1) ? wb_i[0].waddr : REG_ADDR_W'($urandom);
            wb_i[1].wdata = $urandom;
            wb_i[1].pc    = $urandom;
            last_addr[0]  = wb_i[0].waddr;
            last_addr[1]  = wb_i[1].waddr;
        end
        @(negedge clk);
        rd_addr_i[0] = last_addr[0];
        rd_addr_i[1] = last_addr[1];
        wb_i         = '0;
        wait_cycles(DRAIN);
    endtask

    task automatic merge_dcache_requests();
        for (int i = 0; i < NUM_MEM; i++) begin
            @(negedge clk);
            mem_req_i[0] = build_mem_req(i[0]);  // Walks all four strobe patterns
            mem_req_i[1] = build_mem_req(i[1]);
        end
        @(negedge clk);
        mem_req_i = '0;
        wait_cycles(DRAIN);
    endtask

    task automatic raise_control_events();
        for (int i = 0; i < NUM_EVENTS; i++) begin
            @(negedge clk);
            // Lone events first, then random mixes
            except_i       = (i < 5) ? 5'(1 << i) : 5'($urandom);
            redirect_vec_i = event_targets();
            branch_i[0]    = random_branch(1'($urandom));
            branch_i[1]    = random_branch(1'($urandom));
            ex_stall_i     = 1'($urandom);
        end
        @(negedge clk);
        except_i   = '0;
        branch_i   = '0;
        ex_stall_i = 1'b0;
        wait_cycles(DRAIN);
    endtask

    task automatic resolve_branches();
        except_i = '0;
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            @(negedge clk);
            branch_i[0]    = random_branch(i[0]);
            branch_i[1]    = random_branch(i[1]);
            ex_stall_i     = i[2];
            redirect_vec_i = event_targets();
        end
        @(negedge clk);
        branch_i   = '0;
        ex_stall_i = 1'b0;
        wait_cycles(DRAIN);
    endtask

    initial begin
        int unsigned start;
        void'($urandom(32'hd62a));
        reset_i        = 1'b1;
        wb_i           = '0;
        rd_addr_i      = '0;
        mem_req_i      = '0;
        except_i       = '0;
        redirect_vec_i = '0;
        branch_i       = '0;
        ex_stall_i     = 1'b0;
        tests_run      = 0;
        tests_failed   = 0;

        start = assertion_failures();
        apply_reset();
        close_test("reset state", start);
        start = assertion_failures();
        write_and_read_registers();
        close_test("register file", start);
        start = assertion_failures();
        merge_dcache_requests();
        close_test("dcache merge", start);
        start = assertion_failures();
        raise_control_events();
        close_test("event priority", start);
        start = assertion_failures();
        resolve_branches();
        close_test("branch redirect", start);

        $display("Tests run: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_run, tests_failed, assertion_failures());
        if (tests_failed == 0 && assertion_failures() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the tests did not finish", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: hdl/backend_merge_top.sv
module backend_merge_top
    import core_cfg_pkg::*;
    import core_types_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      reset_i,

    // Register file
    input  wb_reg_t       [LANES-1:0]                 wb_i,
    input  logic          [READ_PORTS-1:0][REG_ADDR_W-1:0] rd_addr_i,
    output logic          [READ_PORTS-1:0][XLEN-1:0]       rd_data_o,

    // Data cache
    input  mem_req_t      [LANES-1:0]                 mem_req_i,
    output mem_req_t                                  dcache_req_o,

    // Redirect
    input  except_t                                   except_i,
    input  redirect_vec_t                             redirect_vec_i,
    input  branch_t       [LANES-1:0]                 branch_i,
    input  logic                                      ex_stall_i,
    output redirect_t                                 redirect_o
);

    logic [LANES-1:0] mem_ce;
    logic             dcache_valid;
    mem_req_t         dcache_payload;

    redirect_unit u_redirect (
        .clk           (clk),
        .reset_i       (reset_i),
        .except_i      (except_i),
        .redirect_vec_i(redirect_vec_i),
        .branch_i      (branch_i),
        .ex_stall_i    (ex_stall_i),
        .redirect_o    (redirect_o)
    );

    // Lane strobes come from the request ce bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            mem_ce[i] = mem_req_i[i].ce;
        end
    end

    lane_select #(
        .payload_t(mem_req_t)
    ) u_dcache_select (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (mem_ce),
        .payload_i(mem_req_i),
        .valid_o  (dcache_valid),
        .payload_o(dcache_payload)
    );

    // Held payload keeps its old ce, the registered strobe replaces it
    always_comb begin
        dcache_req_o    = dcache_payload;
        dcache_req_o.ce = dcache_valid;
    end

    regs_file u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_i     (wb_i),
        .rd_addr_i(rd_addr_i),
        .rd_data_o(rd_data_o)
    );

endmodule

// File: hdl/core_cfg_pkg.sv
package core_cfg_pkg;

    // Datapath
    localparam int unsigned XLEN = 32;  // Data and address width
    localparam int unsigned LANES = 2;  // Issue lanes

    // General-purpose register file
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS = 32;
    localparam int unsigned READ_PORTS = 4;  // Two source operands per lane

    // Frontend interface
    localparam int unsigned FTQ_ID_W = 3;  // Fetch target queue id

    // Data-cache request
    localparam int unsigned STRB_W = 4;  // One strobe bit per byte

    // Step from the idle PC to the refetch target
    localparam int unsigned INSTR_BYTES = 4;

endpackage

// File: hdl/core_types_pkg.sv
package core_types_pkg;

    import core_cfg_pkg::*;

    // Register write of one lane at write-back
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc;  // PC of the writing instruction
    } wb_reg_t;

    // Data-cache request of one lane
    typedef struct packed {
        logic              ce;   // Request strobe
        logic              we;   // Store when set, load otherwise
        logic [STRB_W-1:0] sel;  // Byte enables
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   data;
    } mem_req_t;

    // Branch resolution of one lane in execute
    typedef struct packed {
        logic                taken;
        logic [XLEN-1:0]     target;
        logic [FTQ_ID_W-1:0] ftq_id;
    } branch_t;

    // Control events from the commit side
    typedef struct packed {
        logic excp;
        logic tlbrefill;  // Qualifies excp
        logic ertn;
        logic idle;
        logic refetch;
    } except_t;

    // Targets for the control events
    typedef struct packed {
        logic [XLEN-1:0]     eentry;
        logic [XLEN-1:0]     tlbrentry;
        logic [XLEN-1:0]     era;
        logic [XLEN-1:0]     idle_pc;
        logic [FTQ_ID_W-1:0] ctrl_ftq_id;  // FTQ id shared by all events
    } redirect_vec_t;

    // Redirect toward the frontend
    typedef struct packed {
        logic                flush;
        logic [XLEN-1:0]     next_pc;
        logic [FTQ_ID_W-1:0] ftq_id;
    } redirect_t;

endpackage

// File: hdl/lane_select.sv
module lane_select
    import core_cfg_pkg::*;
#(
    parameter type payload_t = logic [XLEN-1:0]
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic     [LANES-1:0]       valid_i,
    input  payload_t [LANES-1:0]       payload_i,
    output logic                       valid_o,
    output payload_t                   payload_o
);

    payload_t sel_payload;

    // Lowest valid lane wins, scan runs from the top so lane 0 lands last
    always_comb begin
        sel_payload = payload_i[0];
        for (int i = LANES - 1; i >= 0; i--) begin
            if (valid_i[i]) begin
                sel_payload = payload_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= |valid_i;
        end
    end

    // Payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (|valid_i) begin
            payload_o <= sel_payload;
        end
    end

endmodule

// File: hdl/redirect_unit.sv
module redirect_unit
    import core_cfg_pkg::*;
    import core_types_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_i,
    input  except_t                  except_i,
    input  redirect_vec_t            redirect_vec_i,
    input  branch_t       [LANES-1:0] branch_i,
    input  logic                     ex_stall_i,
    output redirect_t                redirect_o
);

    logic                event_hit;
    logic [XLEN-1:0]     event_pc;
    logic                event_valid_q;
    logic [XLEN-1:0]     event_pc_q;
    logic [FTQ_ID_W-1:0] event_ftq_id_q;

    logic [LANES-1:0]    branch_valid;
    logic                branch_valid_q;
    branch_t             branch_q;

    // Any control event forces a redirect
    assign event_hit = except_i.excp | except_i.ertn | except_i.idle | except_i.refetch;

    // Fixed event priority
    always_comb begin
        if (except_i.excp) begin
            event_pc = except_i.tlbrefill ? redirect_vec_i.tlbrentry : redirect_vec_i.eentry;
        end else if (except_i.ertn) begin
            event_pc = redirect_vec_i.era;
        end else if (except_i.idle) begin
            event_pc = redirect_vec_i.idle_pc;
        end else begin
            event_pc = redirect_vec_i.idle_pc + XLEN'(INSTR_BYTES);  // Refetch
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            event_valid_q <= 1'b0;
        end else begin
            event_valid_q <= event_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (event_hit) begin
            event_pc_q     <= event_pc;
            event_ftq_id_q <= redirect_vec_i.ctrl_ftq_id;
        end
    end

    // A stalled execute stage may hold a branch with stale operands
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            branch_valid[i] = branch_i[i].taken & ~ex_stall_i;
        end
    end

    lane_select #(
        .payload_t(branch_t)
    ) u_branch_select (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (branch_valid),
        .payload_i(branch_i),
        .valid_o  (branch_valid_q),
        .payload_o(branch_q)
    );

    // Registered event outranks registered branch
    always_comb begin
        redirect_o.flush = event_valid_q | branch_valid_q;
        if (event_valid_q) begin
            redirect_o.next_pc = event_pc_q;
            redirect_o.ftq_id  = event_ftq_id_q;
        end else if (branch_valid_q) begin
            redirect_o.next_pc = branch_q.target;
            redirect_o.ftq_id  = branch_q.ftq_id;
        end else begin
            redirect_o.next_pc = '0;
            redirect_o.ftq_id  = '0;
        end
    end

endmodule

// File: hdl/regs_file.sv
module regs_file
    import core_cfg_pkg::*;
    import core_types_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  wb_reg_t [LANES-1:0]                    wb_i,
    input  logic    [READ_PORTS-1:0][REG_ADDR_W-1:0] rd_addr_i,
    output logic    [READ_PORTS-1:0][XLEN-1:0]       rd_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Lanes written in order so lane 1 lands on top of lane 0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (wb_i[l].we && (wb_i[l].waddr != '0)) begin
                    regs[wb_i[l].waddr] <= wb_i[l].wdata;
                end
            end
        end
    end

    // No bypass of same-cycle writes
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;  // r0 hardwired
            end else begin
                rd_data_o[p] = regs[rd_addr_i[p]];
            end
        end
    end

endmodule

// File: sources.f
hdl/core_cfg_pkg.sv
hdl/core_types_pkg.sv
hdl/lane_select.sv
hdl/redirect_unit.sv
hdl/regs_file.sv
hdl/backend_merge_top.sv
dv/backend_merge_checker.sv
dv/backend_merge_tb.sv
